/* core_fetch.f */
hdl/core_fetch_pkg.sv
hdl/core_instr_pkg.sv
hdl/core_pipe_fetch_buffer.sv
hdl/core_pipe_fetch.sv
hdl/core_pipe_issue.sv
hdl/core_fetch_top.sv
tb/tb_imem_model.sv
tb/tb_core_fetch.sv

/* hdl/core_fetch_pkg.sv */
/*
 * Fetch front end definitions
 * Bus widths, reset vector, buffer sizing and the instruction memory
 * request/response structures
 */
package core_fetch_pkg;

    // --------------------
    // Widths and constants
    // --------------------
    localparam int unsigned fetch_addr_w    = 64;  // Fetch address width
    localparam int unsigned fetch_data_w    = 64;  // Memory read word width
    localparam int unsigned fetch_buf_bytes = 16;  // Fetch buffer capacity

    // Reset vector for fetch address and issue PC
    localparam logic [fetch_addr_w-1:0] fetch_pc_reset = 64'h1000_0000;

    // Byte count of the fetch buffer, 0..16
    typedef logic [$clog2(fetch_buf_bytes+1)-1:0] fetch_depth_t;

    // --------------------
    // Instruction memory bus
    // --------------------
    typedef struct packed {
        logic                    req;   // Read request
        logic [fetch_addr_w-1:0] addr;  // 8-byte aligned
    } imem_req_t;

    typedef struct packed {
        logic                    gnt;   // Request accepted
        logic                    err;   // Bus error, one cycle after gnt
        logic [fetch_data_w-1:0] rdata; // Read data, one cycle after gnt
    } imem_rsp_t;

endpackage

/* hdl/core_fetch_top.sv */
/*
 * Fetch front end top level
 * Fetch stage with its buffer feeding the issue stage
 */
`timescale 1ns/10ps

module core_fetch_top (
    input  logic                                 g_clk,
    input  logic                                 g_resetn,
    input  logic                                 cf_valid,    // Redirect request
    input  logic [core_fetch_pkg::fetch_addr_w-1:0] cf_target,
    output logic                                 cf_ack,
    output core_fetch_pkg::imem_req_t            imem_req,    // To instruction memory
    input  core_fetch_pkg::imem_rsp_t            imem_rsp,    // From instruction memory
    output logic                                 instr_valid, // To decoder
    input  logic                                 instr_ready,
    output core_instr_pkg::issue_instr_t         instr
);
    import core_instr_pkg::*;

    logic        cf_taken;
    logic        s1_i16bit;
    logic        s1_i32bit;
    logic [31:0] s1_instr;
    instr_ferr_t s1_ferr;
    logic        s1_eat_2;
    logic        s1_eat_4;

    core_pipe_fetch core_pipe_fetch_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_valid  (cf_valid),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .cf_taken  (cf_taken),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .s1_i16bit (s1_i16bit),
        .s1_i32bit (s1_i32bit),
        .s1_instr  (s1_instr),
        .s1_ferr   (s1_ferr),
        .s1_eat_2  (s1_eat_2),
        .s1_eat_4  (s1_eat_4)
    );

    core_pipe_issue core_pipe_issue_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .cf_taken    (cf_taken),
        .cf_target   (cf_target),
        .s1_i16bit   (s1_i16bit),
        .s1_i32bit   (s1_i32bit),
        .s1_instr    (s1_instr),
        .s1_ferr     (s1_ferr),
        .s1_eat_2    (s1_eat_2),
        .s1_eat_4    (s1_eat_4),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr)
    );

endmodule

/* hdl/core_instr_pkg.sv */
/*
 * Issued instruction definitions
 * Instruction word with raw and halfword views, fetch error tags and
 * the instruction record handed to the decoder
 */
package core_instr_pkg;

    // Halfword view, lower half holds a compressed instruction
    typedef struct packed {
        logic [15:0] hi;    // Upper halfword of a 32-bit instruction
        logic [15:0] lo;    // Compressed instr or lower half
    } instr_half_t;

    // Same 32 bits seen as one word or as two halfwords
    typedef union packed {
        logic [31:0] raw;   // Full-length word
        instr_half_t half;  // Halfword pair
    } instr_word_u;

    // One error tag per halfword of the window
    typedef logic [1:0] instr_ferr_t;

    // --------------------
    // Issued instruction
    // --------------------
    typedef struct packed {
        logic [63:0] pc;    // Instruction address
        instr_word_u word;  // Upper half zero for 16-bit
        logic        is32;  // Full-length instruction
        instr_ferr_t ferr;  // Fetch error per halfword
    } issue_instr_t;

endpackage

/* hdl/core_pipe_fetch.sv */
/*
 * Instruction fetch stage
 * Issues aligned 8-byte reads, tracks outstanding requests, drops stale
 * responses after a redirect and places fills in the fetch buffer
 */
`timescale 1ns/10ps

module core_pipe_fetch (
    input  logic                                 g_clk,
    input  logic                                 g_resetn,
    input  logic                                 cf_valid,    // Redirect request
    input  logic [core_fetch_pkg::fetch_addr_w-1:0] cf_target, // Redirect target
    output logic                                 cf_ack,      // Redirect accepted
    output logic                                 cf_taken,    // Redirect this cycle
    output core_fetch_pkg::imem_req_t            imem_req,
    input  core_fetch_pkg::imem_rsp_t            imem_rsp,
    output logic                                 s1_i16bit,   // 16-bit instr present
    output logic                                 s1_i32bit,   // 32-bit instr present
    output logic [31:0]                          s1_instr,    // Front of buffer
    output core_instr_pkg::instr_ferr_t          s1_ferr,     // Error tags of window
    input  logic                                 s1_eat_2,    // Issue consumes 2 bytes
    input  logic                                 s1_eat_4     // Issue consumes 4 bytes
);
    import core_fetch_pkg::*;
    import core_instr_pkg::*;

    // --------------------
    // Events
    // --------------------
    logic e_cf;         // Redirect takes effect
    logic e_req;        // Request accepted
    logic imem_recv;    // Response arrives this cycle

    assign e_req    = imem_req.req && imem_rsp.gnt;
    assign cf_ack   = !imem_req.req || imem_rsp.gnt;   // Nothing stalled on the bus
    assign e_cf     = cf_valid && cf_ack;
    assign cf_taken = e_cf;

    // --------------------
    // Buffer signals
    // --------------------
    fetch_depth_t buf_depth;        // Bytes held now
    fetch_depth_t n_buf_depth;      // Bytes held next cycle
    logic [31:0]  buf_data_out;
    instr_ferr_t  buf_error_out;
    logic         buf_fill_en;      // Accepted response to store
    logic         buf_fill_2;
    logic         buf_fill_4;
    logic         buf_fill_6;
    logic         buf_fill_8;
    logic         buf_ready;        // Room for one more word

    // --------------------
    // Request and address
    // --------------------
    logic n_req;

    // Stop requesting once a further word could overflow the buffer
    assign buf_ready = (n_buf_depth <= fetch_depth_t'(fetch_buf_bytes - fetch_data_w/8))
                    && !e_req;
    assign n_req     = buf_ready || (imem_req.req && !imem_rsp.gnt); // Hold under stall

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req.req  <= 1'b0;
            imem_req.addr <= {fetch_pc_reset[fetch_addr_w-1:3], 3'b000};
            imem_recv     <= 1'b0;
        end else begin
            imem_req.req <= n_req;
            imem_recv    <= e_req;                          // Fixed 1-cycle response
            if (e_cf) begin
                imem_req.addr <= {cf_target[fetch_addr_w-1:3], 3'b000};
            end else if (e_req) begin
                imem_req.addr <= imem_req.addr + fetch_addr_w'(fetch_data_w/8);
            end
        end
    end

    // --------------------
    // Stale response filter
    // --------------------
    logic [1:0] outst_q;    // Accepted, response not yet seen
    logic [1:0] n_outst;
    logic [1:0] ign_q;      // Responses still to discard
    logic       ignore_rsp;

    assign n_outst    = outst_q + 2'(e_req) - 2'(imem_recv);
    assign ignore_rsp = |ign_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            outst_q <= 2'd0;
            ign_q   <= 2'd0;
        end else begin
            outst_q <= n_outst;
            if (e_cf) begin
                ign_q <= n_outst;                           // All in flight are stale
            end else if (imem_recv && ignore_rsp) begin
                ign_q <= ign_q - 2'd1;
            end
        end
    end

    // --------------------
    // Fill placement
    // --------------------
    logic       first_pend_q;   // Next fill is first after redirect
    logic [1:0] cf_off_q;       // Halfword offset of the target

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            first_pend_q <= 1'b1;
            cf_off_q     <= fetch_pc_reset[2:1];
        end else if (e_cf) begin
            first_pend_q <= 1'b1;
            cf_off_q     <= cf_target[2:1];
        end else if (buf_fill_en) begin
            first_pend_q <= 1'b0;                           // Later words fill whole
        end
    end

    // Response in the redirect cycle belongs to the old stream
    assign buf_fill_en = imem_recv && !ignore_rsp && !e_cf;
    assign buf_fill_8  = buf_fill_en && (!first_pend_q || cf_off_q == 2'd0);
    assign buf_fill_6  = buf_fill_en && first_pend_q && cf_off_q == 2'd1;
    assign buf_fill_4  = buf_fill_en && first_pend_q && cf_off_q == 2'd2;
    assign buf_fill_2  = buf_fill_en && first_pend_q && cf_off_q == 2'd3;

    // --------------------
    // Instruction present
    // --------------------
    assign s1_i16bit = !e_cf && buf_depth >= fetch_depth_t'(2) && buf_data_out[1:0] != 2'b11;
    assign s1_i32bit = !e_cf && buf_depth >= fetch_depth_t'(4) && buf_data_out[1:0] == 2'b11;
    assign s1_instr  = buf_data_out;
    assign s1_ferr   = buf_error_out;

    core_pipe_fetch_buffer core_pipe_fetch_buffer_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (e_cf),              // Redirect empties the queue
        .data_in   (imem_rsp.rdata),
        .error_in  (imem_rsp.err),
        .fill_en   (buf_fill_en),
        .fill_2    (buf_fill_2),
        .fill_4    (buf_fill_4),
        .fill_6    (buf_fill_6),
        .fill_8    (buf_fill_8),
        .drain_2   (s1_eat_2),
        .drain_4   (s1_eat_4),
        .depth     (buf_depth),
        .n_depth   (n_buf_depth),
        .data_out  (buf_data_out),
        .error_out (buf_error_out)
    );

endmodule

/* hdl/core_pipe_fetch_buffer.sv */
/*
 * Fetch buffer
 * 16-byte queue of halfwords with an error tag each, appends the upper
 * 2/4/6/8 bytes of a read word and drains 2 or 4 bytes from the front
 */
`timescale 1ns/10ps

module core_pipe_fetch_buffer (
    input  logic                                 g_clk,
    input  logic                                 g_resetn,
    input  logic                                 flush,     // Empty the queue
    input  logic [core_fetch_pkg::fetch_data_w-1:0] data_in, // Read word
    input  logic                                 error_in,  // Read word has error
    input  logic                                 fill_en,   // Append this cycle
    input  logic                                 fill_2,    // Upper 2 bytes
    input  logic                                 fill_4,    // Upper 4 bytes
    input  logic                                 fill_6,    // Upper 6 bytes
    input  logic                                 fill_8,    // Whole word
    input  logic                                 drain_2,   // Pop 2 bytes
    input  logic                                 drain_4,   // Pop 4 bytes
    output core_fetch_pkg::fetch_depth_t         depth,     // Bytes held
    output core_fetch_pkg::fetch_depth_t         n_depth,   // Bytes held next cycle
    output logic [31:0]                          data_out,  // Two front halfwords
    output core_instr_pkg::instr_ferr_t          error_out  // Their error tags
);
    import core_fetch_pkg::*;

    logic [15:0]                  hw_q [fetch_buf_bytes/2];  // Index 0 is the front
    logic [15:0]                  hw_d [fetch_buf_bytes/2];
    logic [fetch_buf_bytes/2-1:0] err_q;
    logic [fetch_buf_bytes/2-1:0] err_d;
    logic [3:0]                   base_hw;  // Halfwords left after drain
    logic [3:0]                   fill_hw;  // Halfwords appended
    logic [1:0]                   shift_hw; // Halfwords drained

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        int src;

        fill_hw  = 4'd0;
        shift_hw = 2'd0;
        if (fill_8) fill_hw = 4'd4;
        if (fill_6) fill_hw = 4'd3;
        if (fill_4) fill_hw = 4'd2;
        if (fill_2) fill_hw = 4'd1;
        if (drain_2) shift_hw = 2'd1;
        if (drain_4) shift_hw = 2'd2;
        if (flush) begin
            base_hw = 4'd0;                                 // Old contents dropped
        end else begin
            base_hw = depth[4:1] - 4'(shift_hw);
        end

        // Shift the queue towards the front
        for (int i = 0; i < fetch_buf_bytes/2; i++) begin
            src = i + int'(shift_hw);
            if (src < fetch_buf_bytes/2) begin
                hw_d[i]  = hw_q[src];
                err_d[i] = err_q[src];
            end else begin
                hw_d[i]  = '0;
                err_d[i] = 1'b0;
            end
        end

        // Append upper halfwords of the read word behind the survivors
        if (fill_en) begin
            for (int i = 0; i < fetch_buf_bytes/2; i++) begin
                if (i >= int'(base_hw) && i < int'(base_hw) + int'(fill_hw)) begin
                    src      = i - int'(base_hw) + 4 - int'(fill_hw);
                    hw_d[i]  = data_in[16*src +: 16];
                    err_d[i] = error_in;                    // Whole word shares the tag
                end
            end
        end

        n_depth = {base_hw + (fill_en ? fill_hw : 4'd0), 1'b0};
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge g_clk) begin
        for (int i = 0; i < fetch_buf_bytes/2; i++) begin
            hw_q[i] <= hw_d[i];
        end
        err_q <= err_d;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth <= '0;                                    // Empty after reset
        end else begin
            depth <= n_depth;
        end
    end

    assign data_out  = {hw_q[1], hw_q[0]};
    assign error_out = err_q[1:0];

endmodule

/* hdl/core_pipe_issue.sv */
/*
 * Instruction issue stage
 * Splits the fetch window into 16/32-bit instructions, tracks the PC
 * and hands each instruction to the decoder under valid/ready
 */
`timescale 1ns/10ps

module core_pipe_issue (
    input  logic                                 g_clk,
    input  logic                                 g_resetn,
    input  logic                                 cf_taken,    // Redirect this cycle
    input  logic [core_fetch_pkg::fetch_addr_w-1:0] cf_target, // New PC
    input  logic                                 s1_i16bit,   // 16-bit instr present
    input  logic                                 s1_i32bit,   // 32-bit instr present
    input  logic [31:0]                          s1_instr,    // Fetch window
    input  core_instr_pkg::instr_ferr_t          s1_ferr,     // Window error tags
    output logic                                 s1_eat_2,    // Consume 2 bytes
    output logic                                 s1_eat_4,    // Consume 4 bytes
    output logic                                 instr_valid,
    input  logic                                 instr_ready,
    output core_instr_pkg::issue_instr_t         instr
);
    import core_fetch_pkg::*;
    import core_instr_pkg::*;

    logic [fetch_addr_w-1:0] pc_q;  // PC at buffer front
    instr_word_u             win;   // Window as fetched
    instr_word_u             word;  // Word as issued
    logic                    is32;
    logic                    xfer;  // Handshake completes

    // --------------------
    // Handshake
    // --------------------
    assign instr_valid = s1_i16bit || s1_i32bit;            // Redirect already masked
    assign xfer        = instr_valid && instr_ready;
    assign s1_eat_2    = xfer && s1_i16bit;
    assign s1_eat_4    = xfer && s1_i32bit;

    // Length test and upper half cleanup
    always_comb begin
        win.raw = s1_instr;
        is32    = win.half.lo[1:0] == 2'b11;
        word    = win;
        if (!is32) begin
            word.half.hi = '0;                              // Compressed only
        end
    end

    always_comb begin
        instr.pc   = pc_q;
        instr.word = word;
        instr.is32 = is32;
        instr.ferr = {is32 && s1_ferr[1], s1_ferr[0]};      // Upper tag only if used
    end

    // --------------------
    // PC tracking
    // --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= fetch_pc_reset;
        end else if (cf_taken) begin
            pc_q <= cf_target;                              // Buffer restarts here
        end else if (xfer) begin
            pc_q <= pc_q + (is32 ? fetch_addr_w'(4) : fetch_addr_w'(2));
        end
    end

endmodule

/* tb/tb_core_fetch.sv */
/*
 * Fetch front end testbench
 * Random redirects, back-pressure and grant stalls, with every issued
 * instruction compared against a walk of the hashed memory
 */
`timescale 1ns/10ps

module tb_core_fetch;
    import core_fetch_pkg::*;
    import core_instr_pkg::*;

    localparam int unsigned n_xfers  = 3000;   // Transfers to check
    localparam int unsigned wait_max = 200;    // Cycles allowed per transfer

    logic         g_clk;
    logic         g_resetn;
    logic         cf_valid;
    logic [63:0]  cf_target;
    logic         cf_ack;
    imem_req_t    imem_req;
    imem_rsp_t    imem_rsp;
    logic         instr_valid;
    logic         instr_ready;
    issue_instr_t instr;
    logic [1:0]   stall_rnd;
    logic [31:0]  rnd_state;    // Xorshift state
    logic [63:0]  ref_pc;       // Model PC of next instruction
    logic         bus_stalled;  // Request waited for grant last cycle
    logic [63:0]  stalled_addr; // Address of that request
    int unsigned  xfer_cnt;
    int unsigned  redir_cnt;

    core_fetch_top core_fetch_top_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .cf_valid    (cf_valid),
        .cf_target   (cf_target),
        .cf_ack      (cf_ack),
        .imem_req    (imem_req),
        .imem_rsp    (imem_rsp),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr)
    );

    tb_imem_model imem_model_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .stall_rnd (stall_rnd),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp)
    );

    initial begin
        g_clk = 1'b0;
        forever begin
            #10 g_clk = ~g_clk;                         // 20 ns period
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    function automatic logic [15:0] half_at(input logic [63:0] addr);
        logic [63:0] w;
        w = imem_model_i.mem_word({addr[63:3], 3'b000});
        return w[16*addr[2:1] +: 16];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h (model pc %h)", name, got, exp, ref_pc);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        if (xfer_cnt < 16) begin
            cf_valid    = 1'b0;                         // Clean start from reset vector
            instr_ready = 1'b1;
        end else begin
            cf_valid    = r[4:0] == 5'd0;
            instr_ready = r[6:5] != 2'd0;
        end
        cf_target = fetch_pc_reset + {52'd0, r[18:8], 1'b0}; // Even, offsets 0..6
        stall_rnd = r[20:19];
    endtask

    // Memory bus and redirect handshake rules, once per cycle
    task automatic check_bus();
        check_value("cf_ack", cf_ack, !(imem_req.req && !imem_rsp.gnt)); // Low only in a stall
        check_value("imem_req.addr[2:0]", imem_req.addr[2:0], 64'd0);  // 8-byte aligned
        if (bus_stalled) begin
            check_value("imem_req.req", imem_req.req, 64'd1);           // Held until granted
            check_value("imem_req.addr", imem_req.addr, stalled_addr);
        end
        bus_stalled  = imem_req.req && !imem_rsp.gnt;
        stalled_addr = imem_req.addr;
    endtask

    // Waits for a handshake and restarts the model on redirects
    task automatic wait_transfer();
        int unsigned cycles;
        logic        done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge g_clk);
            drive_inputs();
            #2;
            check_bus();
            if (cf_valid && cf_ack) begin
                check_value("instr_valid", instr_valid, 64'd0);
                ref_pc = cf_target;
                redir_cnt++;
            end else if (instr_valid && instr_ready) begin
                done = 1'b1;
            end
            cycles++;
            if (!done && cycles >= wait_max) begin
                $display("Timeout: no instruction transferred within %0d cycles", wait_max);
                $display("Result: FAILED");
                $fatal(1, "transfer timeout");
            end
        end
    endtask

    task automatic check_xfer();
        logic [15:0] hw0;
        logic [15:0] hw1;
        logic        exp32;
        hw0   = half_at(ref_pc);
        hw1   = half_at(ref_pc + 64'd2);                // May sit in the next word
        exp32 = hw0[1:0] == 2'b11;
        check_value("instr.pc", instr.pc, ref_pc);
        check_value("instr.is32", instr.is32, exp32);
        check_value("instr.word", instr.word.raw, exp32 ? {hw1, hw0} : {16'd0, hw0});
        check_value("instr.ferr", instr.ferr,
                    {exp32 && imem_model_i.mem_err(ref_pc + 64'd2),
                     imem_model_i.mem_err(ref_pc)});
        ref_pc = ref_pc + (exp32 ? 64'd4 : 64'd2);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        g_resetn     = 1'b0;
        cf_valid     = 1'b0;
        cf_target    = fetch_pc_reset;
        instr_ready  = 1'b0;
        stall_rnd    = 2'd0;
        rnd_state    = 32'hdeca_6635;
        ref_pc       = fetch_pc_reset;
        bus_stalled  = 1'b0;
        stalled_addr = '0;
        xfer_cnt     = 0;
        redir_cnt    = 0;
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        while (xfer_cnt < n_xfers) begin
            wait_transfer();
            check_xfer();
            xfer_cnt++;
        end
        $display("%0d transfers checked, %0d redirects", xfer_cnt, redir_cnt);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb/tb_imem_model.sv */
/*
 * Instruction memory model
 * Hashed read data, two error windows, random grant stalls and a
 * response one cycle after each accepted request
 */
`timescale 1ns/10ps

module tb_imem_model (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic [1:0]                stall_rnd,   // Grant delay after an accept
    input  core_fetch_pkg::imem_req_t imem_req,
    output core_fetch_pkg::imem_rsp_t imem_rsp
);
    localparam logic [63:0] err0_lo = 64'h1000_0200;   // First error window
    localparam logic [63:0] err0_hi = 64'h1000_0240;
    localparam logic [63:0] err1_lo = 64'h1000_0610;   // Second error window
    localparam logic [63:0] err1_hi = 64'h1000_0628;

    logic        pend;          // Accepted on the coming edge
    logic [63:0] pend_addr;
    logic [1:0]  stall_left;    // Cycles of withheld grant

    // --------------------
    // Memory contents
    // --------------------
    function automatic logic [31:0] mix32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every address bit folds into the word
    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = mix32(addr[63:32] ^ addr[31:0] ^ 32'h9e37_79b9);
        hi = mix32(lo ^ 32'h7f4a_7c15);
        return {hi, lo};
    endfunction

    function automatic logic mem_err(input logic [63:0] addr);
        logic [63:0] a;
        a = {addr[63:3], 3'b000};                       // Word holding the byte
        return (a >= err0_lo && a < err0_hi) || (a >= err1_lo && a < err1_hi);
    endfunction

    // --------------------
    // Bus behavior
    // --------------------
    initial begin
        imem_rsp   = '0;
        pend       = 1'b0;
        pend_addr  = '0;
        stall_left = 2'd0;
        forever begin
            @(negedge g_clk);
            if (pend) begin
                imem_rsp.rdata = mem_word(pend_addr);   // Cycle after accept
                imem_rsp.err   = mem_err(pend_addr);
            end else begin
                imem_rsp.err = 1'b0;
            end
            if (stall_left != 2'd0) begin
                imem_rsp.gnt = 1'b0;
                stall_left   = stall_left - 2'd1;
            end else begin
                imem_rsp.gnt = 1'b1;
            end
            #2;
            pend = g_resetn && imem_req.req && imem_rsp.gnt;
            if (pend) begin
                pend_addr  = imem_req.addr;
                stall_left = stall_rnd;                 // Next grant 0..3 cycles late
            end
        end
    end

endmodule
